// ==== design/mac_config.svh ====
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// operand, product and sum width
`define MAC_DATA_WIDTH        16

// sideband tag carried from the a channel
`define MAC_USER_WIDTH        4

// default pipeline depths, counted in enabled cycles
`define MAC_MULTIPLIER_DELAY  3
`define MAC_ACCUMULATOR_DELAY 2

`endif

// ==== design/mac_data_pkg.sv ====
`default_nettype none

`include "mac_config.svh"

package mac_data_pkg;

    // two's complement, products and sums wrap at this width
    typedef logic signed [`MAC_DATA_WIDTH-1:0] data_t;

    typedef logic [`MAC_USER_WIDTH-1:0] user_t;  // opaque tag, follows its operand

endpackage

`default_nettype wire

// ==== design/mac_ctrl_pkg.sv ====
`default_nettype none

`include "mac_config.svh"

package mac_ctrl_pkg;

    // which operand operand_join is holding while it waits for a partner
    typedef enum logic [1:0] {
        empty,   // nothing held
        hold_a,  // a operand held with its last and user
        hold_b   // b operand held
    } join_state_t;

endpackage

`default_nettype wire

// ==== design/operand_join.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_join import mac_data_pkg::*, mac_ctrl_pkg::*; (
    input  wire logic  aclk,
    input  wire logic  rst_n,
    input  wire logic  aclken,
    input  wire logic  a_valid,
    input  wire data_t a_data,
    input  wire logic  a_last,
    input  wire user_t a_user,
    input  wire logic  b_valid,
    input  wire data_t b_data,
    output logic       pair_valid,
    output data_t      pair_a,
    output data_t      pair_b,
    output logic       pair_last,
    output user_t      pair_user
);

    join_state_t state;
    join_state_t state_nxt;

    data_t held_data;  // a or b, depending on state
    logic  held_last;
    user_t held_user;

    logic  pair_fire;
    logic  load_a;
    logic  load_b;
    data_t nxt_a;
    data_t nxt_b;
    logic  nxt_last;
    user_t nxt_user;

    always_comb begin
        state_nxt = state;
        pair_fire = 1'b0;
        load_a    = 1'b0;
        load_b    = 1'b0;
        nxt_a     = a_data;
        nxt_b     = b_data;
        nxt_last  = a_last;
        nxt_user  = a_user;
        if (a_valid && b_valid) begin
            // both new strobes pair up, anything held is dropped
            pair_fire = 1'b1;
            state_nxt = empty;
        end else if (a_valid) begin
            if (state == hold_b) begin
                pair_fire = 1'b1;
                nxt_b     = held_data;
                state_nxt = empty;
            end else begin
                load_a    = 1'b1;  // store or replace a held a
                state_nxt = hold_a;
            end
        end else if (b_valid) begin
            if (state == hold_a) begin
                pair_fire = 1'b1;
                nxt_a     = held_data;
                nxt_last  = held_last;  // sideband always from the a side
                nxt_user  = held_user;
                state_nxt = empty;
            end else begin
                load_b    = 1'b1;
                state_nxt = hold_b;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= empty;
            pair_valid <= 1'b0;
        end else if (aclken) begin
            state      <= state_nxt;
            pair_valid <= pair_fire;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            if (load_a) begin
                held_data <= a_data;
                held_last <= a_last;
                held_user <= a_user;
            end else if (load_b) begin
                held_data <= b_data;
            end
            pair_a    <= nxt_a;
            pair_b    <= nxt_b;
            pair_last <= nxt_last;
            pair_user <= nxt_user;
        end
    end

endmodule

`default_nettype wire

// ==== design/fixed_point_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_config.svh"

module fixed_point_multiplier import mac_data_pkg::*; #(
    parameter int DELAY = `MAC_MULTIPLIER_DELAY  // total stages, at least 1
) (
    input  wire logic  aclk,
    input  wire logic  rst_n,
    input  wire logic  aclken,
    input  wire logic  pair_valid,
    input  wire data_t pair_a,
    input  wire data_t pair_b,
    input  wire logic  pair_last,
    input  wire user_t pair_user,
    output logic       prod_valid,
    output data_t      prod_data,
    output logic       prod_last,
    output user_t      prod_user
);

    data_t product;

    logic [DELAY-1:0] valid_pipe;
    data_t            data_pipe [DELAY];
    logic             last_pipe [DELAY];
    user_t            user_pipe [DELAY];

    // evaluated at data width, so only the low bits survive and it wraps
    assign product = pair_a * pair_b;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else if (aclken) begin
            valid_pipe[0] <= pair_valid;
            for (int i = 1; i < DELAY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            data_pipe[0] <= product;
            last_pipe[0] <= pair_last;
            user_pipe[0] <= pair_user;
            for (int i = 1; i < DELAY; i++) begin
                data_pipe[i] <= data_pipe[i-1];
                last_pipe[i] <= last_pipe[i-1];
                user_pipe[i] <= user_pipe[i-1];
            end
        end
    end

    assign prod_valid = valid_pipe[DELAY-1];
    assign prod_data  = data_pipe[DELAY-1];
    assign prod_last  = last_pipe[DELAY-1];
    assign prod_user  = user_pipe[DELAY-1];

endmodule

`default_nettype wire

// ==== design/fixed_point_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_config.svh"

module fixed_point_accumulator import mac_data_pkg::*; #(
    parameter int DELAY = `MAC_ACCUMULATOR_DELAY  // total stages, at least 1
) (
    input  wire logic  aclk,
    input  wire logic  rst_n,
    input  wire logic  aclken,
    input  wire logic  prod_valid,
    input  wire data_t prod_data,
    input  wire logic  prod_last,
    input  wire user_t prod_user,
    output logic       sum_valid,
    output data_t      sum_data,
    output logic       sum_last,
    output user_t      sum_user
);

    logic  acc_valid;
    data_t acc_sum;   // running sum, only moves on valid items
    logic  acc_last;  // last flag of the previous valid item
    user_t acc_user;
    data_t sum_nxt;

    // restart from zero once the previous item closed its packet
    assign sum_nxt = (acc_last ? data_t'(0) : acc_sum) + prod_data;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
            acc_sum   <= '0;
            acc_last  <= 1'b0;
        end else if (aclken) begin
            acc_valid <= prod_valid;
            if (prod_valid) begin
                acc_sum  <= sum_nxt;
                acc_last <= prod_last;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken && prod_valid) begin
            acc_user <= prod_user;
        end
    end

    generate
        if (DELAY == 1) begin : g_no_tail
            assign sum_valid = acc_valid;
            assign sum_data  = acc_sum;
            assign sum_last  = acc_last;
            assign sum_user  = acc_user;
        end else begin : g_tail
            logic [DELAY-2:0] valid_pipe;  // stages 2 .. DELAY
            data_t            data_pipe [DELAY-1];
            logic             last_pipe [DELAY-1];
            user_t            user_pipe [DELAY-1];

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_pipe <= '0;
                end else if (aclken) begin
                    valid_pipe[0] <= acc_valid;
                    for (int i = 1; i < DELAY - 1; i++) begin
                        valid_pipe[i] <= valid_pipe[i-1];
                    end
                end
            end

            always_ff @(posedge aclk) begin
                if (aclken) begin
                    data_pipe[0] <= acc_sum;
                    last_pipe[0] <= acc_last;
                    user_pipe[0] <= acc_user;
                    for (int i = 1; i < DELAY - 1; i++) begin
                        data_pipe[i] <= data_pipe[i-1];
                        last_pipe[i] <= last_pipe[i-1];
                        user_pipe[i] <= user_pipe[i-1];
                    end
                end
            end

            assign sum_valid = valid_pipe[DELAY-2];
            assign sum_data  = data_pipe[DELAY-2];
            assign sum_last  = last_pipe[DELAY-2];
            assign sum_user  = user_pipe[DELAY-2];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== design/mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_top import mac_data_pkg::*; (
    input  wire logic  aclk,
    input  wire logic  rst_n,
    input  wire logic  aclken,  // global stall, holds every register when low
    input  wire logic  a_valid,
    input  wire data_t a_data,
    input  wire logic  a_last,
    input  wire user_t a_user,
    input  wire logic  b_valid,
    input  wire data_t b_data,
    output logic       sum_valid,
    output data_t      sum_data,
    output logic       sum_last,
    output user_t      sum_user
);

    logic  pair_valid;
    data_t pair_a;
    data_t pair_b;
    logic  pair_last;
    user_t pair_user;

    logic  prod_valid;
    data_t prod_data;
    logic  prod_last;
    user_t prod_user;

    operand_join u_join (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .aclken     (aclken),
        .a_valid    (a_valid),
        .a_data     (a_data),
        .a_last     (a_last),
        .a_user     (a_user),
        .b_valid    (b_valid),
        .b_data     (b_data),
        .pair_valid (pair_valid),
        .pair_a     (pair_a),
        .pair_b     (pair_b),
        .pair_last  (pair_last),
        .pair_user  (pair_user)
    );

    fixed_point_multiplier u_mul (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .aclken     (aclken),
        .pair_valid (pair_valid),
        .pair_a     (pair_a),
        .pair_b     (pair_b),
        .pair_last  (pair_last),
        .pair_user  (pair_user),
        .prod_valid (prod_valid),
        .prod_data  (prod_data),
        .prod_last  (prod_last),
        .prod_user  (prod_user)
    );

    fixed_point_accumulator u_acc (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .aclken     (aclken),
        .prod_valid (prod_valid),
        .prod_data  (prod_data),
        .prod_last  (prod_last),
        .prod_user  (prod_user),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data),
        .sum_last   (sum_last),
        .sum_user   (sum_user)
    );

endmodule

`default_nettype wire

// ==== tb/mac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_tb import mac_data_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_LIMIT  = 8;  // enabled cycles for the pipeline to empty
    localparam int NUM_TESTS    = 6;

    typedef struct packed {
        logic  en;
        logic  a_valid;
        data_t a_data;
        logic  a_last;
        user_t a_user;
        logic  b_valid;
        data_t b_data;
    } stim_t;

    typedef struct packed {
        data_t data;
        logic  last;
        user_t user;
        int    test;
    } expect_t;

    logic  aclk;
    logic  rst_n;
    logic  aclken;
    logic  a_valid;
    data_t a_data;
    logic  a_last;
    user_t a_user;
    logic  b_valid;
    data_t b_data;
    logic  sum_valid;
    data_t sum_data;
    logic  sum_last;
    user_t sum_user;

    stim_t   stim_q[$];
    expect_t exp_q[$];
    string   test_name [NUM_TESTS+1];
    int      last_idx [NUM_TESTS+1];  // index of each test's final expected entry
    int      test_err [NUM_TESTS+1];
    int      cur_test;
    int      exp_idx;
    int      extra_count;
    logic    table_ready = 1'b0;

    mac_top u_dut (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .a_valid   (a_valid),
        .a_data    (a_data),
        .a_last    (a_last),
        .a_user    (a_user),
        .b_valid   (b_valid),
        .b_data    (b_data),
        .sum_valid (sum_valid),
        .sum_data  (sum_data),
        .sum_last  (sum_last),
        .sum_user  (sum_user)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD/2) aclk = ~aclk;
    end

    task automatic open_test(input int n, input string name);
        cur_test     = n;
        test_name[n] = name;
    endtask

    task automatic stim_row(input int av, input int ad, input int al, input int au,
                            input int bv, input int bd);
        stim_t r;
        r.en      = 1'b1;
        r.a_valid = (av != 0);
        r.a_data  = data_t'(ad);
        r.a_last  = (al != 0);
        r.a_user  = user_t'(au);
        r.b_valid = (bv != 0);
        r.b_data  = data_t'(bd);
        stim_q.push_back(r);
    endtask

    task automatic idle_rows(input int n);
        repeat (n) stim_row(0, 0, 0, 0, 0, 0);
    endtask

    task automatic stall_rows(input int n);
        stim_t r;
        r = '0;  // aclken low, data inputs keep their previous values
        repeat (n) stim_q.push_back(r);
    endtask

    task automatic expect_sum(input int data, input int last, input int user);
        expect_t e;
        e.data = data_t'(data);
        e.last = (last != 0);
        e.user = user_t'(user);
        e.test = cur_test;
        exp_q.push_back(e);
    endtask

    // columns: a_valid, a_data, a_last, a_user, b_valid, b_data
    task automatic build_tables();
        open_test(1, "simultaneous operands");
        stim_row(1, 1, 1, 1, 1, 9);     expect_sum(9, 1, 1);
        stim_row(1, 2, 0, 2, 1, 3);     expect_sum(6, 0, 2);
        stim_row(1, 4, 1, 3, 1, 5);     expect_sum(26, 1, 3);
        idle_rows(2);

        open_test(2, "packet restart");
        stim_row(1, 3, 0, 4, 1, 7);     expect_sum(21, 0, 4);
        stim_row(1, -2, 1, 5, 1, 4);    expect_sum(13, 1, 5);
        stim_row(1, 6, 0, 6, 1, 6);     expect_sum(36, 0, 6);  // own product only
        stim_row(1, 1, 1, 7, 1, 10);    expect_sum(46, 1, 7);
        idle_rows(2);

        open_test(3, "staggered operands");
        stim_row(1, 5, 1, 8, 0, 0);
        idle_rows(3);
        stim_row(0, 0, 0, 0, 1, 11);    expect_sum(55, 1, 8);
        stim_row(0, 0, 0, 0, 1, -3);    // b first this time
        idle_rows(2);
        stim_row(1, 7, 1, 9, 0, 0);     expect_sum(-21, 1, 9);
        idle_rows(2);

        open_test(4, "replacement");
        stim_row(1, 100, 0, 10, 0, 0);  // overwritten before any b shows up
        idle_rows(1);
        stim_row(1, 12, 1, 11, 0, 0);
        stim_row(0, 0, 0, 0, 1, 4);     expect_sum(48, 1, 11);
        idle_rows(2);

        open_test(5, "wrap-around");
        stim_row(1, -300, 0, 12, 1, 250);  expect_sum(-9464, 0, 12);
        stim_row(1, 200, 0, 13, 1, 200);   expect_sum(30536, 0, 13);
        stim_row(1, -1, 1, 14, 1, -1);     expect_sum(30537, 1, 14);
        stim_row(1, 181, 0, 1, 1, 181);    expect_sum(32761, 0, 1);
        stim_row(1, 10, 1, 2, 1, 1);       expect_sum(-32765, 1, 2);
        idle_rows(2);

        open_test(6, "clock-enable stall");
        stim_row(1, 2, 0, 3, 1, 3);     expect_sum(6, 0, 3);
        stim_row(1, 4, 0, 4, 1, 5);     expect_sum(26, 0, 4);
        stall_rows(4);
        stim_row(1, -6, 0, 5, 0, 0);
        stall_rows(3);                  // a operand held in the join stage
        stim_row(0, 0, 0, 0, 1, 7);     expect_sum(-16, 0, 5);
        stim_row(1, 3, 1, 6, 1, 3);     expect_sum(-7, 1, 6);
        stall_rows(5);
        idle_rows(1);
        stall_rows(3);                  // first sum strobe held through the stall

        for (int t = 0; t <= NUM_TESTS; t++) begin
            last_idx[t] = -1;
            test_err[t] = 0;
        end
        foreach (exp_q[i]) begin
            last_idx[exp_q[i].test] = i;
        end
    endtask

    task automatic drive_row(input stim_t r);
        aclken = r.en;
        if (r.en) begin
            a_valid = r.a_valid;
            a_data  = r.a_data;
            a_last  = r.a_last;
            a_user  = r.a_user;
            b_valid = r.b_valid;
            b_data  = r.b_data;
        end
    endtask

    task automatic check_output();
        expect_t e;
        assert (exp_idx < exp_q.size()) else begin
            $display("ERROR at %0t: sum_valid strobe with no expected result left, sum_data %0d",
                     $time, sum_data);
            extra_count++;
        end
        if (exp_idx < exp_q.size()) begin
            e = exp_q[exp_idx];
            assert (sum_data == e.data) else begin
                $display("MISMATCH at %0t: sum_data expected %0d, got %0d",
                         $time, $signed(e.data), sum_data);
                test_err[e.test]++;
            end
            assert (sum_last == e.last) else begin
                $display("MISMATCH at %0t: sum_last expected %0b, got %0b",
                         $time, e.last, sum_last);
                test_err[e.test]++;
            end
            assert (sum_user == e.user) else begin
                $display("MISMATCH at %0t: sum_user expected %0d, got %0d",
                         $time, e.user, sum_user);
                test_err[e.test]++;
            end
            if (exp_idx == last_idx[e.test]) begin
                $display("test %0d %s: %s", e.test, test_name[e.test],
                         (test_err[e.test] == 0) ? "pass" : "fail");
            end
            exp_idx++;
        end
    endtask

    // a strobe counts only when the next edge is enabled
    always @(negedge aclk) begin
        if (rst_n && aclken && sum_valid) begin
            check_output();
        end
    end

    task automatic final_report();
        int pass_count;
        int fail_count;
        pass_count = 0;
        fail_count = 0;
        assert (exp_idx == exp_q.size()) else
            $display("ERROR: %0d expected results never appeared on the sum channel",
                     exp_q.size() - exp_idx);
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (last_idx[t] >= exp_idx) begin
                $display("test %0d %s: fail, results missing", t, test_name[t]);
                fail_count++;
            end else if (test_err[t] != 0) begin
                fail_count++;
            end else begin
                pass_count++;
            end
        end
        $display("tests passed: %0d, tests failed: %0d, extra strobes: %0d",
                 pass_count, fail_count, extra_count);
        if (fail_count == 0 && extra_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin : main
        stim_t idle;
        int    wait_cycles;
        rst_n       = 1'b0;
        aclken      = 1'b1;
        a_valid     = 1'b0;
        a_data      = '0;
        a_last      = 1'b0;
        a_user      = '0;
        b_valid     = 1'b0;
        b_data      = '0;
        exp_idx     = 0;
        extra_count = 0;
        build_tables();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        foreach (stim_q[i]) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            drive_row(stim_q[i]);
        end
        idle    = '0;
        idle.en = 1'b1;
        @(posedge aclk);
        #DRIVE_DELAY;
        drive_row(idle);
        wait_cycles = 0;
        while (exp_idx < exp_q.size() && wait_cycles < DRAIN_LIMIT) begin
            @(posedge aclk);
            wait_cycles++;
        end
        final_report();
    end

    initial begin : watchdog
        wait (table_ready);
        #((stim_q.size() + 20) * CLK_PERIOD);
        $display("ERROR: watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/mac_data_pkg.sv
design/mac_ctrl_pkg.sv
design/operand_join.sv
design/fixed_point_multiplier.sv
design/fixed_point_accumulator.sv
design/mac_top.sv
tb/mac_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run mac_tb with Verilator, pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert -f files.f --top-module mac_tb \
    --Mdir "$BUILD_DIR" -o mac_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/mac_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
